/* hw/core_defs.svh */
// ----------------------------------------
// Widths and reset vector for the RV64 slice
// Register index width must cover REG_COUNT
// ----------------------------------------
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN         64
`define ILEN         32
`define REG_COUNT    32
`define REG_IDX_W    5

// First fetch address out of reset
`define RESET_VECTOR 64'h0000_0000_8000_0000

`define CNT_W        64

`endif

/* hw/isa_pkg.sv */
// ----------------------------------------
// RV64 encodings for the supported subset
// Only 32-bit formats, no compressed forms
// ----------------------------------------
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010
    } alu_funct3_t;

    // ----------------------------------------
    // Instruction format views
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;       // Bits 31:12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_word_t;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
// ----------------------------------------
// Internal encodings of the multicycle core
// ----------------------------------------
`default_nettype none

package core_pkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT
    } alu_op_t;

    // One instruction in flight, no pipelining
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_RELEASE,
        ST_EXECUTE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
// ----------------------------------------
// Unknown opcodes and funct3 decode as a no-op
// LUI reads x0 so the ALU passes the immediate
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module instr_decoder (
    input  wire isa_pkg::instr_word_t    instr,
    output logic [`REG_IDX_W-1:0]        rs1,
    output logic [`REG_IDX_W-1:0]        rs2,
    output logic [`REG_IDX_W-1:0]        rd,
    output logic [`XLEN-1:0]             imm,
    output core_pkg::alu_op_t            alu_op,
    output logic                         use_imm,
    output logic                         rd_we_dec,
    output logic                         is_branch,
    output logic                         is_jal,
    output isa_pkg::branch_funct3_t      branch_funct3
);

    logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
    logic             writes;   // Supported op with a destination

    // Same word, different slicing per format
    assign imm_i = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_b = {{(`XLEN-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {{(`XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
    assign imm_j = {{(`XLEN-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    assign rs2           = instr.r.rs2;
    assign rd            = instr.r.rd;
    assign branch_funct3 = isa_pkg::branch_funct3_t'(instr.b.funct3);
    assign rd_we_dec     = writes && (rd != '0);

    always_comb begin
        rs1       = instr.r.rs1;
        imm       = imm_i;
        alu_op    = core_pkg::ALU_ADD;
        use_imm   = 1'b0;
        writes    = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (instr.r.opcode)
            isa_pkg::OP_LUI: begin
                rs1     = '0;
                imm     = imm_u;
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            isa_pkg::OP_IMM, isa_pkg::OP_REG: begin
                use_imm = (instr.r.opcode == isa_pkg::OP_IMM);
                writes  = 1'b1;
                case (instr.r.funct3)
                    isa_pkg::F3_ADD_SUB: begin
                        // funct7 bit 5 is part of the immediate on OP_IMM
                        if (!use_imm && instr.r.funct7[5]) alu_op = core_pkg::ALU_SUB;
                    end
                    isa_pkg::F3_SLL: alu_op = core_pkg::ALU_SLL;
                    isa_pkg::F3_SLT: alu_op = core_pkg::ALU_SLT;
                    default:         writes = 1'b0;
                endcase
            end
            isa_pkg::OP_BRANCH: begin
                imm       = imm_b;
                is_branch = (instr.b.funct3[2:1] != 2'b01);   // 010 and 011 are reserved
            end
            isa_pkg::OP_JAL: begin
                imm    = imm_j;
                is_jal = 1'b1;
                writes = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
// ----------------------------------------
// Integer ALU, combinational
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module alu (
    input  wire [`XLEN-1:0]        a,
    input  wire [`XLEN-1:0]        b,
    input  wire core_pkg::alu_op_t alu_op,
    output logic [`XLEN-1:0]       result
);

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: result = a + b;
            core_pkg::ALU_SUB: result = a - b;
            core_pkg::ALU_SLL: result = a << b[5:0];   // RV64 shamt
            core_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:           result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
// ----------------------------------------
// Static not-taken, any taken target redirects
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module branch_unit (
    input  wire [`XLEN-1:0]              pc,
    input  wire [`XLEN-1:0]              rs1_val,
    input  wire [`XLEN-1:0]              rs2_val,
    input  wire [`XLEN-1:0]              imm,
    input  wire                          is_branch,
    input  wire                          is_jal,
    input  wire isa_pkg::branch_funct3_t branch_funct3,
    output logic [`XLEN-1:0]             next_pc,
    output logic                         redirect,
    output logic [`XLEN-1:0]             link
);

    logic cond;

    always_comb begin
        case (branch_funct3)
            isa_pkg::F3_BEQ:  cond = (rs1_val == rs2_val);
            isa_pkg::F3_BNE:  cond = (rs1_val != rs2_val);
            isa_pkg::F3_BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
            isa_pkg::F3_BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            isa_pkg::F3_BLTU: cond = (rs1_val < rs2_val);
            isa_pkg::F3_BGEU: cond = (rs1_val >= rs2_val);
            default:          cond = 1'b0;
        endcase
    end

    assign link     = pc + `XLEN'd4;
    assign redirect = (is_branch && cond) || is_jal;
    assign next_pc  = redirect ? pc + imm : link;

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// ----------------------------------------
// x0 is not stored and always reads zero
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module reg_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`REG_IDX_W-1:0]  rs1,
    input  wire [`REG_IDX_W-1:0]  rs2,
    input  wire [`REG_IDX_W-1:0]  rd,
    input  wire                   we,
    input  wire [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]      rs1_val,
    output logic [`XLEN-1:0]      rs2_val
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/core_ctrl.sv */
// ----------------------------------------
// Four-phase fetch, then one execute cycle
// Memory may stall any phase indefinitely
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module core_ctrl (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    imem_ack,
    input  wire [`ILEN-1:0]        imem_data,
    input  wire [`XLEN-1:0]        next_pc,
    input  wire                    rd_we_dec,
    input  wire                    is_branch,
    input  wire                    is_jal,
    input  wire                    redirect,
    input  wire [`REG_IDX_W-1:0]   rd,
    input  wire [`XLEN-1:0]        wb_data,
    output logic                   imem_req,
    output logic [`XLEN-1:0]       imem_addr,
    output isa_pkg::instr_word_t   instr,
    output logic [`XLEN-1:0]       pc,
    output logic                   wb_en,
    output logic                   retire_valid,
    output logic [`XLEN-1:0]       retire_pc,
    output logic [`REG_IDX_W-1:0]  retire_rd,
    output logic                   retire_we,
    output logic [`XLEN-1:0]       retire_data,
    output logic                   branch_strobe,
    output logic                   mispredict_strobe
);

    core_pkg::ctrl_state_t state;
    logic                  executing;

    assign executing = (state == core_pkg::ST_EXECUTE);
    assign wb_en     = executing && rd_we_dec;
    assign imem_addr = pc;

    // ----------------------------------------
    // Handshake and sequencing
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= core_pkg::ST_FETCH;
            imem_req          <= 1'b0;
            pc                <= `RESET_VECTOR;
            retire_valid      <= 1'b0;
            retire_we         <= 1'b0;
            branch_strobe     <= 1'b0;
            mispredict_strobe <= 1'b0;
        end else begin
            retire_valid      <= 1'b0;   // Pulses only
            branch_strobe     <= 1'b0;
            mispredict_strobe <= 1'b0;
            case (state)
                core_pkg::ST_FETCH: begin
                    if (imem_req && imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= core_pkg::ST_RELEASE;
                    end else begin
                        imem_req <= 1'b1;   // First request after reset
                    end
                end
                core_pkg::ST_RELEASE: begin
                    if (!imem_ack) state <= core_pkg::ST_EXECUTE;
                end
                core_pkg::ST_EXECUTE: begin
                    pc                <= next_pc;
                    retire_valid      <= 1'b1;
                    retire_we         <= wb_en;
                    branch_strobe     <= is_branch || is_jal;
                    mispredict_strobe <= redirect;
                    imem_req          <= 1'b1;   // Ack already seen low
                    state             <= core_pkg::ST_FETCH;
                end
                default: state <= core_pkg::ST_FETCH;
            endcase
        end
    end

    // Instruction and retire payload
    always_ff @(posedge clk) begin
        if (state == core_pkg::ST_FETCH && imem_req && imem_ack) instr <= imem_data;
        if (executing) begin
            retire_pc   <= pc;
            retire_rd   <= rd;
            retire_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* hw/perf_counters.sv */
// ----------------------------------------
// Free-running counters, wrap without saturation
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module perf_counters (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               retire_strobe,
    input  wire               branch_strobe,
    input  wire               mispredict_strobe,
    output logic [`CNT_W-1:0] cycles,
    output logic [`CNT_W-1:0] inst_retired,
    output logic [`CNT_W-1:0] branches,
    output logic [`CNT_W-1:0] branch_mispredicts
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles             <= '0;
            inst_retired       <= '0;
            branches           <= '0;
            branch_mispredicts <= '0;
        end else begin
            cycles <= cycles + 1'b1;
            if (retire_strobe)     inst_retired       <= inst_retired + 1'b1;
            if (branch_strobe)     branches           <= branches + 1'b1;
            if (mispredict_strobe) branch_mispredicts <= branch_mispredicts + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/supernova_core.sv */
// ----------------------------------------
// Multicycle RV64 integer slice, one op in flight
// No loads, stores, CSRs or interrupts
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module supernova_core (
    input  wire                   clk,
    input  wire                   rst_n,
    output logic                  imem_req,
    output logic [`XLEN-1:0]      imem_addr,
    input  wire                   imem_ack,
    input  wire [`ILEN-1:0]       imem_data,
    output logic                  retire_valid,
    output logic                  retire_we,
    output logic [`XLEN-1:0]      retire_pc,
    output logic [`XLEN-1:0]      retire_data,
    output logic [`REG_IDX_W-1:0] retire_rd,
    output logic [`CNT_W-1:0]     cycles,
    output logic [`CNT_W-1:0]     inst_retired,
    output logic [`CNT_W-1:0]     branches,
    output logic [`CNT_W-1:0]     branch_mispredicts
);

    isa_pkg::instr_word_t    instr;
    isa_pkg::branch_funct3_t branch_funct3;
    core_pkg::alu_op_t       alu_op;
    logic [`REG_IDX_W-1:0]   rs1, rs2, rd;
    logic [`XLEN-1:0]        pc, next_pc, link, imm;
    logic [`XLEN-1:0]        rs1_val, rs2_val, alu_b, alu_result, wb_data;
    logic                    use_imm, rd_we_dec, is_branch, is_jal, redirect, wb_en;
    logic                    branch_strobe, mispredict_strobe;

    // ----------------------------------------
    // Operand and write-back selection
    // ----------------------------------------
    assign alu_b   = use_imm ? imm : rs2_val;
    assign wb_data = is_jal ? link : alu_result;   // LUI comes through the ALU

    core_ctrl u_core_ctrl (
        .clk, .rst_n, .imem_ack, .imem_data, .next_pc, .rd_we_dec, .is_branch, .is_jal,
        .redirect, .rd, .wb_data, .imem_req, .imem_addr, .instr, .pc, .wb_en,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data,
        .branch_strobe, .mispredict_strobe
    );

    instr_decoder u_instr_decoder (
        .instr, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .rd_we_dec,
        .is_branch, .is_jal, .branch_funct3
    );

    reg_file u_reg_file (
        .clk, .rst_n, .rs1, .rs2, .rd, .we(wb_en), .wdata(wb_data), .rs1_val, .rs2_val
    );

    alu u_alu (.a(rs1_val), .b(alu_b), .alu_op, .result(alu_result));

    branch_unit u_branch_unit (
        .pc, .rs1_val, .rs2_val, .imm, .is_branch, .is_jal, .branch_funct3,
        .next_pc, .redirect, .link
    );

    perf_counters u_perf_counters (
        .clk, .rst_n, .retire_strobe(retire_valid), .branch_strobe, .mispredict_strobe,
        .cycles, .inst_retired, .branches, .branch_mispredicts
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// ----------------------------------------
// 8 ns clock, rst_n low for 16 cycles
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Falls at 1 ns so the async reset sees a real edge
    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // Released away from the rising edge
    end

endmodule

`default_nettype wire

/* tests/supernova_core_tb.sv */
// ----------------------------------------
// Directed program with random fetch stalls
// Fetches past the program are never acked
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module supernova_core_tb;

    // Branch kinds keep funct3 in bits 2:0
    typedef enum logic [3:0] {
        K_LUI, K_ADDI, K_SLTI, K_SLLI, K_ADD, K_SUB, K_SLL, K_SLT,
        K_BEQ = 4'd8, K_BNE = 4'd9, K_JAL = 4'd10,
        K_BLT = 4'd12, K_BGE = 4'd13, K_BLTU = 4'd14, K_BGEU = 4'd15
    } kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
    } op_t;

    logic                  clk, rst_n;
    logic                  imem_req, imem_ack;
    logic [`XLEN-1:0]      imem_addr;
    logic [`ILEN-1:0]      imem_data;
    logic                  retire_valid, retire_we;
    logic [`XLEN-1:0]      retire_pc, retire_data;
    logic [`REG_IDX_W-1:0] retire_rd;
    logic [`CNT_W-1:0]     cycles, inst_retired, branches, branch_mispredicts;

    logic [`ILEN-1:0]      prog [0:63];   // Memory image
    op_t                   ops [0:63];    // Same program for the model
    int                    prog_len = 0;
    int                    alu_end;

    logic [`XLEN-1:0]      model_regs [0:`REG_COUNT-1];
    logic [`XLEN-1:0]      model_pc, exp_data, exp_next;
    logic                  exp_we, exp_has_rd;
    int                    retired, exp_branches, exp_redirects;

    tb_clock u_tb_clock (.clk, .rst_n);

    supernova_core u_supernova_core (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_ack, .imem_data,
        .retire_valid, .retire_we, .retire_pc, .retire_data, .retire_rd,
        .cycles, .inst_retired, .branches, .branch_mispredicts
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic int pc_index(input logic [`XLEN-1:0] pc);
        return int'((pc - `RESET_VECTOR) >> 2);
    endfunction

    // ----------------------------------------
    // Assembler and reference model
    // ----------------------------------------
    function automatic logic [`ILEN-1:0] encode(input op_t op);
        case (op.kind)
            K_LUI:   return {op.imm[31:12], op.rd, 7'b0110111};
            K_ADDI:  return {op.imm[11:0], op.rs1, 3'b000, op.rd, 7'b0010011};
            K_SLTI:  return {op.imm[11:0], op.rs1, 3'b010, op.rd, 7'b0010011};
            K_SLLI:  return {6'd0, op.imm[5:0], op.rs1, 3'b001, op.rd, 7'b0010011};
            K_ADD:   return {7'd0, op.rs2, op.rs1, 3'b000, op.rd, 7'b0110011};
            K_SUB:   return {7'b0100000, op.rs2, op.rs1, 3'b000, op.rd, 7'b0110011};
            K_SLL:   return {7'd0, op.rs2, op.rs1, 3'b001, op.rd, 7'b0110011};
            K_SLT:   return {7'd0, op.rs2, op.rs1, 3'b010, op.rd, 7'b0110011};
            K_JAL:   return {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd,
                             7'b1101111};
            default: return {op.imm[12], op.imm[10:5], op.rs2, op.rs1, op.kind[2:0],
                             op.imm[4:1], op.imm[11], 7'b1100011};
        endcase
    endfunction

    task automatic emit(input kind_t kind, input int rd, input int rs1, input int rs2,
                        input longint imm);
        op_t op;
        op.kind        = kind;
        op.rd          = 5'(rd);
        op.rs1         = 5'(rs1);
        op.rs2         = 5'(rs2);
        op.imm         = imm;
        ops[prog_len]  = op;
        prog[prog_len] = encode(op);
        prog_len++;
    endtask

    task automatic model_step(input op_t op);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic             taken;
        a        = model_regs[op.rs1];
        b        = model_regs[op.rs2];
        taken    = 1'b0;
        exp_data = '0;
        case (op.kind)
            K_LUI:   exp_data = {{32{op.imm[31]}}, op.imm[31:12], 12'd0};
            K_ADDI:  exp_data = a + op.imm;
            K_SLTI:  exp_data = {63'd0, $signed(a) < $signed(op.imm)};
            K_SLLI:  exp_data = a << op.imm[5:0];
            K_ADD:   exp_data = a + b;
            K_SUB:   exp_data = a - b;
            K_SLL:   exp_data = a << b[5:0];
            K_SLT:   exp_data = {63'd0, $signed(a) < $signed(b)};
            K_BEQ:   taken = (a == b);
            K_BNE:   taken = (a != b);
            K_BLT:   taken = ($signed(a) < $signed(b));
            K_BGE:   taken = ($signed(a) >= $signed(b));
            K_BLTU:  taken = (a < b);
            K_BGEU:  taken = (a >= b);
            default: begin   // JAL
                exp_data = model_pc + 64'd4;
                taken    = 1'b1;
            end
        endcase
        exp_has_rd = !(op.kind[3] && op.kind != K_JAL);
        exp_we     = exp_has_rd && (op.rd != 5'd0);
        exp_next   = taken ? model_pc + op.imm : model_pc + 64'd4;
        if (exp_we) model_regs[op.rd] = exp_data;
        if (op.kind[3]) exp_branches++;   // Conditional branches and JAL
        if (taken) exp_redirects++;       // Static not-taken
    endtask

    task automatic build_program();
        for (int i = 0; i < `REG_COUNT; i++) model_regs[i] = '0;
        model_pc      = `RESET_VECTOR;
        retired       = 0;
        exp_branches  = 0;
        exp_redirects = 0;
        emit(K_LUI,   1,  0,  0, 'h8765_4000);   // Sign-extends to 64 bits
        emit(K_ADDI,  2,  0,  0, 100);
        emit(K_ADDI,  3,  0,  0, -7);
        emit(K_SLTI,  4,  3,  0, 5);
        emit(K_SLTI,  5,  2,  0, -1);
        emit(K_SLLI,  6,  2,  0, 40);            // Shift above 31
        emit(K_ADD,   7,  1,  2, 0);
        emit(K_SUB,   8,  2,  3, 0);
        emit(K_SLL,   9,  3,  4, 0);
        emit(K_SLT,  10,  3,  2, 0);
        emit(K_SLT,  11,  2,  3, 0);
        emit(K_ADDI,  0,  2,  0, 5);             // Dropped write to x0
        emit(K_ADD,  12,  0,  2, 0);             // x0 must read zero
        alu_end = prog_len;
        // Each condition not taken, then taken over a skipped slot
        emit(K_BEQ,   0,  2,  3, 8);
        emit(K_BEQ,   0,  2, 12, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_BNE,   0,  2, 12, 8);
        emit(K_BNE,   0,  2,  3, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_BLT,   0,  2,  3, 8);
        emit(K_BLT,   0,  3,  2, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_BGE,   0,  3,  2, 8);
        emit(K_BGE,   0,  2, 12, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_BLTU,  0,  3,  2, 8);
        emit(K_BLTU,  0,  2,  3, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_BGEU,  0,  2,  3, 8);
        emit(K_BGEU,  0,  3,  2, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_ADDI, 16,  0,  0, 3);
        emit(K_ADDI, 15, 15,  0, 1);
        emit(K_BNE,   0, 15, 16, -4);            // Backward loop, three passes
        emit(K_JAL,  13,  0,  0, 8);
        emit(K_ADDI, 31, 31,  0, 1);
        emit(K_ADDI, 14, 13,  0, 0);             // Uses the link value
    endtask

    // ----------------------------------------
    // Instruction memory, ack raised and dropped after 0 to 3 cycles
    // ----------------------------------------
    initial begin : fetch_responder
        int               delay;
        int               idx;
        logic             prev_req;
        logic [`XLEN-1:0] prev_addr;
        imem_ack  = 1'b0;
        imem_data = '0;
        void'($urandom(5));
        delay     = int'($urandom % 4);
        prev_req  = 1'b0;
        prev_addr = '0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                // imem_ack here is the value the DUT saw at the last rising edge
                if (imem_req && !prev_req && imem_ack) begin
                    fail_run("imem_req rose while imem_ack was still high");
                end
                if (!imem_req && prev_req && !imem_ack) begin
                    fail_run("imem_req fell before imem_ack was raised");
                end
                if (imem_req && prev_req) check_value("imem_addr", imem_addr, prev_addr);
                idx = pc_index(imem_addr);
                if (imem_req && !imem_ack && idx >= 0 && idx < prog_len) begin
                    if (delay == 0) begin
                        imem_ack  = 1'b1;
                        imem_data = prog[idx];
                        delay     = int'($urandom % 4);   // Hold before the drop
                    end else begin
                        delay--;
                    end
                end else if (!imem_req && imem_ack) begin
                    if (delay == 0) begin
                        imem_ack = 1'b0;
                        delay    = int'($urandom % 4);
                    end else begin
                        delay--;
                    end
                end
            end
            prev_req  = imem_req;
            prev_addr = imem_addr;
        end
    end

    task automatic wait_fetch();
        int waited;
        waited = 0;
        while (!imem_req) begin
            @(negedge clk);
            waited++;
            if (waited > 64) fail_run("timeout waiting for imem_req");
        end
    endtask

    task automatic wait_retire();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 64) fail_run("timeout waiting for retire_valid");
        end while (!retire_valid);
    endtask

    task automatic run_until(input int end_idx);
        int idx;
        idx = pc_index(model_pc);
        while (idx != end_idx) begin
            if (idx < 0 || idx >= prog_len || retired > 500) begin
                fail_run("model PC left the program or the program never ended");
            end
            wait_fetch();
            check_value("imem_addr", imem_addr, model_pc);
            model_step(ops[idx]);
            wait_retire();
            check_value("retire_pc", retire_pc, model_pc);
            check_value("retire_we", 64'(retire_we), 64'(exp_we));
            if (exp_has_rd) check_value("retire_rd", 64'(retire_rd), 64'(ops[idx].rd));
            if (exp_we) check_value("retire_data", retire_data, exp_data);
            model_pc = exp_next;
            retired++;
            idx = pc_index(model_pc);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        int waited;
        waited = 0;
        @(negedge clk);   // Reset is already low here
        check_value("imem_req", 64'(imem_req), 64'd0);
        check_value("retire_valid", 64'(retire_valid), 64'd0);
        check_value("cycles", cycles, 64'd0);
        check_value("inst_retired", inst_retired, 64'd0);
        check_value("branches", branches, 64'd0);
        check_value("branch_mispredicts", branch_mispredicts, 64'd0);
        while (!rst_n) begin
            @(posedge clk);
            waited++;
            if (waited > 64) fail_run("timeout waiting for reset release");
        end
        @(negedge clk);
        wait_fetch();
        check_value("imem_addr", imem_addr, `RESET_VECTOR);
    endtask

    task automatic test_alu_ops();
        run_until(alu_end);
    endtask

    task automatic test_branches();
        run_until(prog_len);
    endtask

    task automatic test_counters();
        repeat (2) @(negedge clk);   // Counters trail the strobes by one cycle
        check_value("inst_retired", inst_retired, 64'(retired));
        check_value("branches", branches, 64'(exp_branches));
        check_value("branch_mispredicts", branch_mispredicts, 64'(exp_redirects));
        check_value("cycles >= 3 * retired", 64'(cycles >= 64'(3 * retired)), 64'd1);
        check_value("imem_addr", imem_addr, model_pc);   // Stalled past the end
    endtask

    initial begin
        build_program();
        test_reset_state();
        test_alu_ops();
        test_branches();
        test_counters();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* supernova_core.f */
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/instr_decoder.sv
hw/alu.sv
hw/branch_unit.sv
hw/reg_file.sv
hw/core_ctrl.sv
hw/perf_counters.sv
hw/supernova_core.sv
tests/tb_clock.sv
tests/supernova_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
# A $fatal in the testbench gives a nonzero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module supernova_core_tb \
    -f supernova_core.f \
    -o supernova_core_sim
./obj_dir/supernova_core_sim
